//--- verilog/sys_pkg.sv
// ----------------------------------------------------------------------
// Shared types and constants for the serial-controlled board I/O block.
// ----------------------------------------------------------------------
package sys_pkg;

	typedef logic [7:0] uart_byte_t;   // One serial data byte.
	typedef logic [3:0] led_t;         // LED outputs.
	typedef logic [3:0] sw_t;          // Switch inputs.

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

	// Received byte, qualified by a one-cycle valid pulse.
	typedef struct packed {
		logic       valid;
		uart_byte_t data;
	} rx_word_t;

	// Send request for the transmitter.
	typedef struct packed {
		logic       start;
		uart_byte_t data;
	} tx_req_t;

	// Command opcodes sit in the upper nibble of a command byte.
	localparam logic [3:0] OP_SET_LED    = 4'd1;
	localparam logic [3:0] OP_READ_SW    = 4'd2;
	localparam logic [3:0] OP_TOGGLE_LED = 4'd3;

	localparam uart_byte_t REPLY_ERR = 8'hEE;   // Answer to an unknown opcode.

endpackage

//--- verilog/uart_rx.sv
// ----------------------------------------------------------------------
// UART receiver, 8N1. Samples each bit at mid-period and emits one
// byte per frame with a good stop bit.
// ----------------------------------------------------------------------
`timescale 1ns/1ns
module uart_rx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic              clk,
	input  logic              i_rst_n,
	input  logic              i_rxd,
	output sys_pkg::rx_word_t o_rx
);
	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] CNT_MID = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] CNT_END = CNT_W'(CLKS_PER_BIT - 1);

	logic [2:0]          rxd_sync;   // Two synchronizer flops plus one of history.
	logic                rxd;
	logic                rxd_fall;
	sys_pkg::rx_state_t  state;
	logic [CNT_W-1:0]    cnt;
	logic [2:0]          bit_idx;
	sys_pkg::uart_byte_t shift;
	logic                valid;

	assign rxd      = rxd_sync[1];
	assign rxd_fall = rxd_sync[2] & ~rxd_sync[1];

	// The line idles high, so the synchronizer comes out of reset high.
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			rxd_sync <= '1;
		end else begin
			rxd_sync <= {rxd_sync[1:0], i_rxd};
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state   <= sys_pkg::RX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			valid   <= 1'b0;
		end else begin
			valid <= 1'b0;
			case (state)
				sys_pkg::RX_IDLE: begin
					cnt <= '0;
					if (rxd_fall)
						state <= sys_pkg::RX_START;
				end
				sys_pkg::RX_START: begin
					if (cnt == CNT_MID) begin
						// A start bit that is high again by mid-bit was only a glitch.
						cnt     <= '0;
						bit_idx <= '0;
						state   <= rxd ? sys_pkg::RX_IDLE : sys_pkg::RX_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				sys_pkg::RX_DATA: begin
					if (cnt == CNT_END) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= sys_pkg::RX_STOP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				sys_pkg::RX_STOP: begin
					if (cnt == CNT_END) begin
						valid <= rxd;                   // A low stop bit drops the frame.
						state <= sys_pkg::RX_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= sys_pkg::RX_IDLE;
			endcase
		end
	end

	// Data arrives LSB first, so bits enter at the top and move down.
	always_ff @(posedge clk) begin
		if (state == sys_pkg::RX_DATA && cnt == CNT_END)
			shift <= {rxd, shift[7:1]};
	end

	assign o_rx.valid = valid;
	assign o_rx.data  = shift;

endmodule

//--- verilog/uart_tx.sv
// ----------------------------------------------------------------------
// UART transmitter, 8N1. Sends one byte per start request and holds
// the line high while idle.
// ----------------------------------------------------------------------
`timescale 1ns/1ns
module uart_tx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic             clk,
	input  logic             i_rst_n,
	input  sys_pkg::tx_req_t i_tx,
	output logic             o_txd,
	output logic             o_busy
);
	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] CNT_END = CNT_W'(CLKS_PER_BIT - 1);

	sys_pkg::tx_state_t  state;
	logic [CNT_W-1:0]    cnt;
	logic [2:0]          bit_idx;
	sys_pkg::uart_byte_t shift;   // Bit 0 is the data bit on the line.

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state   <= sys_pkg::TX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			o_txd   <= 1'b1;
		end else begin
			case (state)
				sys_pkg::TX_IDLE: begin
					cnt     <= '0;
					bit_idx <= '0;
					o_txd   <= 1'b1;
					if (i_tx.start) begin
						o_txd <= 1'b0;                 // Start bit.
						state <= sys_pkg::TX_START;
					end
				end
				sys_pkg::TX_START: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_END) begin
						cnt   <= '0;
						o_txd <= shift[0];
						state <= sys_pkg::TX_DATA;
					end
				end
				sys_pkg::TX_DATA: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_END) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							o_txd <= 1'b1;             // Stop bit.
							state <= sys_pkg::TX_STOP;
						end else begin
							o_txd <= shift[1];
						end
					end
				end
				sys_pkg::TX_STOP: begin
					cnt <= cnt + 1'b1;
					if (cnt == CNT_END)
						state <= sys_pkg::TX_IDLE;
				end
				default: state <= sys_pkg::TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == sys_pkg::TX_IDLE && i_tx.start)
			shift <= i_tx.data;
		else if (state == sys_pkg::TX_DATA && cnt == CNT_END)
			shift <= shift >> 1;
	end

	assign o_busy = (state != sys_pkg::TX_IDLE);

endmodule

//--- verilog/io_cmd_ctrl.sv
// ----------------------------------------------------------------------
// Command controller. Decodes received command bytes, drives the LEDs,
// samples the switches and queues one reply per valid command.
// ----------------------------------------------------------------------
`timescale 1ns/1ns
module io_cmd_ctrl (
	input  logic                clk,
	input  logic                i_rst_n,
	input  sys_pkg::rx_word_t   i_rx,
	input  sys_pkg::sw_t        i_sw,
	input  logic                i_tx_busy,
	output sys_pkg::tx_req_t    o_tx,
	output sys_pkg::led_t       o_led
);
	sys_pkg::sw_t        sw_meta;
	sys_pkg::sw_t        sw_sync;
	sys_pkg::led_t       led_q;
	sys_pkg::led_t       led_nxt;
	logic [3:0]          opcode;
	logic [3:0]          arg;
	sys_pkg::uart_byte_t reply;
	logic                pend_valid;
	sys_pkg::uart_byte_t pend_data;
	logic                tx_fire;
	logic                slot_free;

	// The switches are asynchronous to clk.
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			sw_meta <= '0;
			sw_sync <= '0;
		end else begin
			sw_meta <= i_sw;
			sw_sync <= sw_meta;
		end
	end

	assign opcode = i_rx.data[7:4];
	assign arg    = i_rx.data[3:0];

	// Command decode. The reply is formed from the new LED value, so a
	// toggle reports the state after the XOR.
	always_comb begin
		led_nxt = led_q;
		reply   = sys_pkg::REPLY_ERR;
		case (opcode)
			sys_pkg::OP_SET_LED: begin
				led_nxt = arg;
				reply   = i_rx.data;                    // Echo of the command.
			end
			sys_pkg::OP_TOGGLE_LED: begin
				led_nxt = led_q ^ arg;
				reply   = {sys_pkg::OP_TOGGLE_LED, led_nxt};
			end
			sys_pkg::OP_READ_SW: begin
				reply = {sys_pkg::OP_READ_SW, sw_sync};
			end
			default: begin
				reply = sys_pkg::REPLY_ERR;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			led_q <= '0;
		end else if (i_rx.valid) begin
			led_q <= led_nxt;
		end
	end

	// The pending slot feeds the transmitter directly. A reply written here
	// starts in the next cycle if the transmitter is idle, otherwise it
	// waits for busy to fall.
	assign tx_fire   = pend_valid & ~i_tx_busy;
	assign slot_free = ~pend_valid | tx_fire;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			pend_valid <= 1'b0;
		end else if (i_rx.valid && slot_free) begin
			pend_valid <= 1'b1;
		end else if (tx_fire) begin
			pend_valid <= 1'b0;
		end
	end

	// With the slot still full, a new reply is lost. That only happens
	// when the host sends faster than the reply line can drain.
	always_ff @(posedge clk) begin
		if (i_rx.valid && slot_free)
			pend_data <= reply;
	end

	assign o_tx.start = tx_fire;
	assign o_tx.data  = pend_data;
	assign o_led      = led_q;

endmodule

//--- verilog/io_sys.sv
// ----------------------------------------------------------------------
// Board I/O top level. UART receiver, command controller and UART
// transmitter sharing one bit period derived from clock and baud.
// ----------------------------------------------------------------------
`timescale 1ns/1ns
module io_sys #(
	parameter int CLK_FREQ_HZ = 100_000_000,
	parameter int UART_BAUD   = 6_250_000
) (
	input  logic          clk,
	input  logic          i_rst_n,
	input  logic          i_rxd,
	input  sys_pkg::sw_t  i_sw,
	output logic          o_txd,
	output sys_pkg::led_t o_led
);
	// Clock cycles per serial bit. The UART blocks need at least 4.
	localparam int CLKS_PER_BIT = CLK_FREQ_HZ / UART_BAUD;

	sys_pkg::rx_word_t rx_word;
	sys_pkg::tx_req_t  tx_req;
	logic              tx_busy;

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_rx (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_rxd   (i_rxd),
		.o_rx    (rx_word)
	);

	io_cmd_ctrl u_io_cmd_ctrl (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_rx      (rx_word),
		.i_sw      (i_sw),
		.i_tx_busy (tx_busy),
		.o_tx      (tx_req),
		.o_led     (o_led)
	);

	// The transmitter may send a reply while the next command arrives.
	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_tx (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_tx    (tx_req),
		.o_txd   (o_txd),
		.o_busy  (tx_busy)
	);

endmodule

//--- sim/io_sys_tb.sv
// ----------------------------------------------------------------------
// Testbench for the board I/O block. Sends UART commands, decodes the
// replies on o_txd and checks them and the LEDs against a model.
// ----------------------------------------------------------------------
`timescale 1ns/1ns
module io_sys_tb;
	localparam int BIT_CLKS      = 16;             // 100 MHz over 6.25 Mbaud.
	localparam int FRAME_CLKS    = 10 * BIT_CLKS;
	localparam int REPLY_TIMEOUT = 3 * FRAME_CLKS;

	logic          clk;
	logic          i_rst_n;
	logic          i_rxd;
	sys_pkg::sw_t  i_sw;
	logic          o_txd;
	sys_pkg::led_t o_led;

	integer              seed = 32'h706f;
	int                  err_count = 0;
	int                  check_count = 0;
	int                  timeout_count = 0;
	int                  mon_err_count = 0;
	sys_pkg::led_t       model_led;
	sys_pkg::sw_t        sw_val;
	sys_pkg::uart_byte_t reply_buf [0:63];    // Ring of decoded reply bytes.
	logic [5:0]          reply_wr = '0;
	logic [5:0]          reply_rd = '0;
	logic                mon_busy = 1'b0;
	int                  mon_cnt;
	int                  mon_bit;
	sys_pkg::uart_byte_t mon_shift;

	io_sys #(
		.CLK_FREQ_HZ (100_000_000),
		.UART_BAUD   (6_250_000)
	) DUT (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_rxd   (i_rxd),
		.i_sw    (i_sw),
		.o_txd   (o_txd),
		.o_led   (o_led)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reply decoder. Bit k of a frame is sampled BIT_CLKS/2 cycles into its period.
	always @(negedge clk) begin
		if (!i_rst_n) begin
			mon_busy = 1'b0;
		end else if (!mon_busy) begin
			if (o_txd === 1'b0) begin
				mon_busy = 1'b1;
				mon_cnt  = 0;
			end
		end else begin
			mon_cnt = mon_cnt + 1;
			if (mon_cnt % BIT_CLKS == BIT_CLKS / 2) begin
				mon_bit = mon_cnt / BIT_CLKS;
				if (mon_bit == 0) begin
					if (o_txd !== 1'b0) begin
						$display("Error at %0t: start bit on o_txd did not last", $time);
						mon_err_count = mon_err_count + 1;
						mon_busy = 1'b0;
					end
				end else if (mon_bit <= 8) begin
					mon_shift = {o_txd, mon_shift[7:1]};   // LSB first.
				end else begin
					if (o_txd === 1'b1) begin
						reply_buf[reply_wr] = mon_shift;
						reply_wr = reply_wr + 6'd1;
					end else begin
						$display("Error at %0t: reply frame has a low stop bit", $time);
						mon_err_count = mon_err_count + 1;
					end
					mon_busy = 1'b0;
				end
			end
		end
	end

	// Model of the command rule. Returns the reply and gives the next LED value.
	function automatic sys_pkg::uart_byte_t expected_reply(input sys_pkg::uart_byte_t cmd,
			input sys_pkg::led_t led, input sys_pkg::sw_t sw, output sys_pkg::led_t led_next);
		logic [3:0] op;
		logic [3:0] arg;
		op       = cmd[7:4];
		arg      = cmd[3:0];
		led_next = led;
		if (op == sys_pkg::OP_SET_LED) begin
			led_next = arg;
			return cmd;
		end else if (op == sys_pkg::OP_TOGGLE_LED) begin
			led_next = led ^ arg;
			return {sys_pkg::OP_TOGGLE_LED, led_next};
		end else if (op == sys_pkg::OP_READ_SW) begin
			return {sys_pkg::OP_READ_SW, sw};
		end
		return sys_pkg::REPLY_ERR;
	endfunction

	task automatic check_byte(input string name, input sys_pkg::uart_byte_t exp,
			input sys_pkg::uart_byte_t act);
		check_count = check_count + 1;
		if (act !== exp) begin
			$display("** Error at %0t: %s expected 8'h%h, got 8'h%h", $time, name, exp, act);
			err_count = err_count + 1;
		end
	endtask

	task automatic check_led(input string name, input sys_pkg::led_t exp,
			input sys_pkg::led_t act);
		check_count = check_count + 1;
		if (act !== exp) begin
			$display("** Error at %0t: %s expected 4'h%h, got 4'h%h", $time, name, exp, act);
			err_count = err_count + 1;
		end
	endtask

	// Serializes one 8N1 frame onto i_rxd. Called on a falling edge.
	task automatic send_byte(input sys_pkg::uart_byte_t data, input bit bad_stop);
		int i;
		i_rxd = 1'b0;
		repeat (BIT_CLKS) @(negedge clk);
		for (i = 0; i < 8; i++) begin
			i_rxd = data[i];
			repeat (BIT_CLKS) @(negedge clk);
		end
		i_rxd = bad_stop ? 1'b0 : 1'b1;
		repeat (BIT_CLKS) @(negedge clk);
		i_rxd = 1'b1;
	endtask

	task automatic wait_reply(output sys_pkg::uart_byte_t data, output bit got);
		int n;
		got  = 1'b0;
		data = '0;
		for (n = 0; n < REPLY_TIMEOUT && !got; n++) begin
			if (reply_rd != reply_wr) begin
				data     = reply_buf[reply_rd];
				reply_rd = reply_rd + 6'd1;
				got      = 1'b1;
			end else begin
				@(negedge clk);
			end
		end
		if (!got) begin
			$display("Timeout at %0t: no reply on o_txd within %0d cycles", $time,
				REPLY_TIMEOUT);
			timeout_count = timeout_count + 1;
		end
	endtask

	// One command, one reply, then the LEDs against the model.
	task automatic run_cmd(input sys_pkg::uart_byte_t cmd);
		sys_pkg::uart_byte_t exp_reply;
		sys_pkg::uart_byte_t act_reply;
		sys_pkg::led_t       led_next;
		bit                  got;
		exp_reply = expected_reply(cmd, model_led, sw_val, led_next);
		send_byte(cmd, 1'b0);
		wait_reply(act_reply, got);
		if (got)
			check_byte("o_txd reply", exp_reply, act_reply);
		check_led("o_led", led_next, o_led);
		model_led = led_next;
	endtask

	initial begin
		sys_pkg::uart_byte_t b2b_cmd [3];
		sys_pkg::uart_byte_t b2b_exp [3];
		sys_pkg::uart_byte_t act;
		sys_pkg::led_t       led_next;
		logic [31:0]         rnd;
		logic [31:0]         idx;
		logic [3:0]          op;
		bit                  got;
		bit                  idle_ok;
		int                  n;
		i_rst_n   = 1'b0;
		i_rxd     = 1'b1;
		i_sw      = '0;
		sw_val    = '0;
		model_led = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		i_rst_n = 1'b1;

		idle_ok = 1'b1;
		for (n = 0; n < 2 * FRAME_CLKS; n++) begin
			@(negedge clk);
			if (o_txd !== 1'b1)
				idle_ok = 1'b0;
		end
		if (!idle_ok || reply_rd != reply_wr) begin
			$display("Error at %0t: o_txd left idle after reset", $time);
			err_count = err_count + 1;
		end
		check_led("o_led", '0, o_led);

		for (n = 0; n < 6; n++) begin
			rnd = $random(seed);
			run_cmd({sys_pkg::OP_SET_LED, rnd[3:0]});
		end
		for (n = 0; n < 6; n++) begin
			rnd = $random(seed);
			run_cmd({sys_pkg::OP_TOGGLE_LED, rnd[3:0]});
		end
		// Switches settle for four bit periods before each read.
		for (n = 0; n < 6; n++) begin
			rnd    = $random(seed);
			sw_val = rnd[3:0];
			i_sw   = sw_val;
			repeat (4 * BIT_CLKS) @(negedge clk);
			run_cmd({sys_pkg::OP_READ_SW, rnd[7:4]});
		end
		for (n = 0; n < 6; n++) begin
			rnd = $random(seed);
			idx = rnd % 32'd13;                 // Opcodes 0 and 4 to 15.
			op  = (idx == 32'd0) ? 4'd0 : idx[3:0] + 4'd3;
			run_cmd({op, rnd[7:4]});
		end

		// The dropped frame would change every LED if it were accepted.
		send_byte({sys_pkg::OP_SET_LED, ~model_led}, 1'b1);
		repeat (2 * FRAME_CLKS) @(negedge clk);
		if (reply_rd != reply_wr) begin
			$display("Error at %0t: reply sent for a frame with a low stop bit", $time);
			err_count = err_count + 1;
			reply_rd = reply_wr;
		end
		check_led("o_led", model_led, o_led);

		rnd = $random(seed);
		b2b_cmd[0] = {sys_pkg::OP_SET_LED, rnd[3:0]};
		b2b_cmd[1] = {sys_pkg::OP_TOGGLE_LED, rnd[7:4]};
		b2b_cmd[2] = {sys_pkg::OP_READ_SW, rnd[11:8]};
		for (n = 0; n < 3; n++) begin
			b2b_exp[n] = expected_reply(b2b_cmd[n], model_led, sw_val, led_next);
			model_led  = led_next;
		end
		for (n = 0; n < 3; n++)
			send_byte(b2b_cmd[n], 1'b0);
		for (n = 0; n < 3; n++) begin
			wait_reply(act, got);
			if (got)
				check_byte("o_txd reply", b2b_exp[n], act);
		end
		check_led("o_led", model_led, o_led);

		err_count = err_count + mon_err_count;
		$display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, err_count,
			timeout_count);
		if (err_count == 0 && timeout_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
verilog/sys_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/io_cmd_ctrl.sv
verilog/io_sys.sv
sim/io_sys_tb.sv

//--- run.sh
#!/bin/sh
# Compile the board I/O design and its testbench with Verilator, run the
# simulation into a log file and decide pass or fail from that log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=io_sys_sim

verilator --binary --timing --timescale 1ns/1ns \
	-f flist.f --top-module io_sys_tb \
	-Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator compile failed."
	exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG."
exit 1
